/* build.f */
+incdir+hdl
hdl/f8_isa_pkg.sv
hdl/f8_bus_pkg.sv
hdl/f8_alu.sv
hdl/f8_regfile.sv
hdl/f8_fetch.sv
hdl/f8_execute.sv
hdl/f8_core.sv
tb/f8_core_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := f8_core_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing

SOURCES := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)

.PHONY: all run lint clean

all: run

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb/f8_core_tb.sv */
// f8 core testbench
`default_nettype none
`include "f8_settings.svh"

module f8_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import f8_isa_pkg::*;
	import f8_bus_pkg::*;

	localparam int CLK_HALF_NS = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 64;
	localparam int WATCHDOG_NS = NUM_TESTS * (CYCLES_PER_TEST + RESET_CYCLES + 8) * 2 * CLK_HALF_NS;
	localparam logic [31:0] LFSR_SEED = 32'hd027_8265;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic [23:0] iread_data = 24'h000000;
	logic [15:0] dread_data = 16'h0000;
	logic [15:0] iread_addr;
	logic [15:0] dread_addr;
	dwrite_t     dwrite;
	logic        trap;

	logic [7:0]  mem [0:65535];
	logic [15:0] ia_q;
	logic [15:0] da_q;
	logic [15:0] asm_pc;
	logic [31:0] lfsr_state = LFSR_SEED;
	logic        trap_seen = 1'b0;
	int          exec_cycle = 0;

	// stores seen on dwrite and stores the program should make
	logic [15:0] st_addr [$];
	logic [15:0] st_data [$];
	logic [1:0]  st_en [$];
	int          st_cycle [$];
	logic [15:0] exp_addr [$];
	logic [15:0] exp_data [$];
	logic [1:0]  exp_en [$];

	f8_core u_dut (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.dread_data(dread_data),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.dwrite(dwrite),
		.trap(trap)
	);

	always #CLK_HALF_NS clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic expect_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("** Error %s: expected %0h, actual %0h", name, expected, actual));
	endtask

	// addresses sampled at the rising edge and data driven on the falling edge
	always @(posedge clk)
	begin
		ia_q <= iread_addr;
		da_q <= dread_addr;
		if (dwrite.en != 2'b00)
		begin
			if (trap_seen)
				abort_run("a store appeared on dwrite after the trap");
			if (dwrite.en[0])
				mem[dwrite.addr] = dwrite.data[7:0];
			if (dwrite.en[1])
				mem[dwrite.addr + 16'd1] = dwrite.data[15:8];
			st_addr.push_back(dwrite.addr);
			st_data.push_back(dwrite.data);
			st_en.push_back(dwrite.en);
			st_cycle.push_back(exec_cycle);
		end
	end

	always @(negedge clk)
	begin
		iread_data = {mem[ia_q + 16'd2], mem[ia_q + 16'd1], mem[ia_q]};
		dread_data = {mem[da_q + 16'd1], mem[da_q]};
	end

	function automatic logic next_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b)
			lfsr_state = lfsr_state ^ LFSR_TAPS;
		return b;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		v = 8'h00;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], next_bit()};
		return v;
	endfunction

	// xl after one byte ALU operation
	function automatic logic [7:0] byte_alu_model(input opcode_t op, input logic [7:0] a,
		input logic [7:0] b);
		case (op)
			ADD_XL_IMMD:
				return a + b;
			SUB_XL_IMMD:
				return a - b;
			AND_XL_IMMD:
				return a & b;
			OR_XL_IMMD:
				return a | b;
			XOR_XL_IMMD:
				return a ^ b;
			INC_XL:
				return a + 8'd1;
			default:
				return a - 8'd1;
		endcase
	endfunction

	task automatic put_byte(input logic [7:0] b);
		mem[asm_pc] = b;
		asm_pc = asm_pc + 16'd1;
	endtask

	task automatic put_op(input opcode_t op);
		put_byte(op);
	endtask

	task automatic put_op_imm8(input opcode_t op, input logic [7:0] imm);
		put_byte(op);
		put_byte(imm);
	endtask

	task automatic put_op_imm16(input opcode_t op, input logic [15:0] imm);
		put_byte(op);
		put_byte(imm[7:0]);
		put_byte(imm[15:8]);
	endtask

	task automatic expect_store(input logic [15:0] addr, input logic [15:0] data,
		input logic [1:0] en);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_en.push_back(en);
	endtask

	// background pattern so stale code never looks like a program
	task automatic new_program();
		for (int a = 0; a < 65536; a++)
			mem[a[15:0]] = a[7:0] ^ a[15:8] ^ 8'h3c;
		asm_pc = `F8_RESET_VECTOR;
		exp_addr.delete();
		exp_data.delete();
		exp_en.delete();
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		repeat (RESET_CYCLES)
		begin
			@(negedge clk);
			expect_equal("reset iread_addr", 32'(`F8_RESET_VECTOR), 32'(iread_addr));
			expect_equal("reset dwrite.en", 0, 32'(dwrite.en));
			expect_equal("reset trap", 0, 32'(trap));
		end
		expect_equal("first fetch address", 32'(`F8_RESET_VECTOR), 32'(ia_q));
		reset = 1'b0;
	endtask

	task automatic start_run();
		trap_seen = 1'b0;
		exec_cycle = 0;
		st_addr.delete();
		st_data.delete();
		st_en.delete();
		st_cycle.delete();
		apply_reset();
	endtask

	task automatic step_cycle();
		@(negedge clk);
		exec_cycle = exec_cycle + 1;
		if (trap)
		begin
			trap_seen = 1'b1;
			// park the core in reset right after the trap
			reset = 1'b1;
		end
	endtask

	task automatic wait_for_trap();
		while (!trap_seen)
			step_cycle();
	endtask

	task automatic compare_stores(input string name);
		expect_equal({name, " store count"}, 32'(exp_addr.size()), 32'(st_addr.size()));
		foreach (exp_addr[i])
		begin
			expect_equal({name, " store addr"}, 32'(exp_addr[i]), 32'(st_addr[i]));
			expect_equal({name, " store en"}, 32'(exp_en[i]), 32'(st_en[i]));
			if (exp_en[i][0])
				expect_equal({name, " store low"}, 32'(exp_data[i][7:0]), 32'(st_data[i][7:0]));
			if (exp_en[i][1])
				expect_equal({name, " store high"}, 32'(exp_data[i][15:8]),
					32'(st_data[i][15:8]));
		end
	endtask

	task automatic test_reset();
		new_program();
		put_op_imm8(LD_XL_IMMD, 8'h5a);
		put_op(TRAP);
		start_run();
		step_cycle();
		// second fetch follows the 2-byte first instruction
		expect_equal("reset second fetch", 32'(`F8_RESET_VECTOR + 16'd2), 32'(ia_q));
		wait_for_trap();
		expect_equal("reset trap cycle", 2, exec_cycle);
		compare_stores("reset");
	endtask

	task automatic test_byte_alu();
		opcode_t     ops [7];
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  res;
		logic [15:0] addr;
		opcode_t     op;
		ops = '{ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD, INC_XL, DEC_XL};
		new_program();
		addr = 16'h8000;
		for (int i = 0; i < 7; i++)
		begin
			a = rand_byte();
			b = rand_byte();
			op = ops[i];
			res = byte_alu_model(op, a, b);
			put_op_imm8(LD_XL_IMMD, a);
			if (op == INC_XL || op == DEC_XL)
				put_op(op);
			else
				put_op_imm8(op, b);
			put_op_imm16(LD_DIR_XL, addr);
			expect_store(addr, {8'h00, res}, 2'b01);
			addr = addr + 16'd1;
		end
		put_op(TRAP);
		start_run();
		wait_for_trap();
		compare_stores("byte alu");
	endtask

	task automatic test_word_path();
		logic [15:0] w;
		logic [7:0]  d;
		logic [15:0] sum;
		new_program();
		w = {rand_byte(), rand_byte()};
		d = rand_byte();
		sum = w + {{8{d[7]}}, d};
		put_op_imm16(LDW_Y_IMMD, w);
		put_op_imm8(ADDW_Y_D, d);
		put_op(LDW_X_Y);
		put_op(LDW_Z_Y);
		put_op_imm16(LDW_DIR_Y, 16'h8100);
		// the copy into x shows up as xl
		put_op_imm16(LD_DIR_XL, 16'h8102);
		put_op(TRAP);
		expect_store(16'h8100, sum, 2'b11);
		expect_store(16'h8102, {8'h00, sum[7:0]}, 2'b01);
		start_run();
		wait_for_trap();
		compare_stores("word path");
		expect_equal("word mem low", 32'(sum[7:0]), 32'(mem[16'h8100]));
		expect_equal("word mem high", 32'(sum[15:8]), 32'(mem[16'h8101]));
	endtask

	task automatic test_load_store();
		logic [7:0] v;
		new_program();
		v = rand_byte();
		mem[16'h9000] = v;
		mem[16'h9001] = 8'hff;
		put_op_imm16(LD_XL_DIR, 16'h9000);
		put_op(INC_XL);
		put_op_imm16(LD_DIR_XL, 16'h9100);
		put_op_imm16(LD_XL_DIR, 16'h9001);
		put_op(INC_XL);
		put_op_imm16(LD_DIR_XL, 16'h9101);
		put_op(TRAP);
		expect_store(16'h9100, {8'h00, v + 8'd1}, 2'b01);
		expect_store(16'h9101, 16'h0000, 2'b01);
		start_run();
		wait_for_trap();
		compare_stores("load store");
	endtask

	task automatic test_branches();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  a2;
		logic [7:0]  b2;
		logic [8:0]  sum9;
		logic [15:0] mark;
		logic        zero;
		new_program();
		mark = 16'h6000;
		for (int r = 0; r < 4; r++)
		begin
			a = rand_byte();
			b = r[0] ? a : rand_byte();
			zero = ((a ^ b) == 8'h00);
			put_op_imm8(LD_XL_IMMD, a);
			put_op_imm8(XOR_XL_IMMD, b);
			// displacement 5 hops over one 3-byte store
			put_op_imm8(JRZ_D, 8'd5);
			put_op_imm16(LD_DIR_XL, mark);
			if (!zero)
				expect_store(mark, {8'h00, a ^ b}, 2'b01);
			put_op_imm8(JRNZ_D, 8'd5);
			put_op_imm16(LD_DIR_XL, mark + 16'd1);
			if (zero)
				expect_store(mark + 16'd1, {8'h00, a ^ b}, 2'b01);
			a2 = r[1] ? (rand_byte() | 8'h80) : (rand_byte() & 8'h7f);
			b2 = r[1] ? (rand_byte() | 8'h80) : (rand_byte() & 8'h7f);
			sum9 = {1'b0, a2} + {1'b0, b2};
			put_op_imm8(LD_XL_IMMD, a2);
			put_op_imm8(ADD_XL_IMMD, b2);
			put_op_imm8(JRC_D, 8'd5);
			put_op_imm16(LD_DIR_XL, mark + 16'd2);
			if (!sum9[8])
				expect_store(mark + 16'd2, {8'h00, sum9[7:0]}, 2'b01);
			put_op_imm16(JP_IMMD, asm_pc + 16'd6);
			put_op_imm16(LD_DIR_XL, mark + 16'd3);
			mark = mark + 16'd8;
		end
		put_op(TRAP);
		start_run();
		wait_for_trap();
		compare_stores("branches");
	endtask

	task automatic test_trap();
		new_program();
		put_op_imm8(LD_XL_IMMD, 8'ha5);
		put_op_imm16(LD_DIR_XL, 16'h7000);
		put_op(NOP);
		put_op(NOP);
		put_op(TRAP);
		put_op_imm16(LD_DIR_XL, 16'h7001);
		expect_store(16'h7000, 16'h00a5, 2'b01);
		start_run();
		wait_for_trap();
		expect_equal("trap cycle", 5, exec_cycle);
		repeat (4)
		begin
			@(negedge clk);
			expect_equal("trap after run", 0, 32'(trap));
		end
		compare_stores("trap");
		expect_equal("trap store cycle", 2, st_cycle[0]);
	endtask

	initial
	begin
		test_reset();
		test_byte_alu();
		test_word_path();
		test_load_store();
		test_branches();
		test_trap();
		$display("Done: no errors");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired because trap never arrived");
	end

endmodule

`default_nettype wire

/* hdl/f8_core.sv */
// f8 core top level
`default_nettype none

module f8_core (
	input  logic                clk,
	input  logic                reset,
	input  logic [23:0]         iread_data,
	input  logic [15:0]         dread_data,
	output logic [15:0]         iread_addr,
	output logic [15:0]         dread_addr,
	output f8_bus_pkg::dwrite_t dwrite,
	output logic                trap
);
	import f8_isa_pkg::*;
	import f8_bus_pkg::*;

	logic [23:0] inst;
	logic [15:0] x;
	logic [15:0] y;
	reg_write_t  wr;
	flags_t      next_flags;

	f8_fetch u_fetch (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.next_flags(next_flags),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.inst(inst)
	);

	// z and the next values stay internal in this cut-down core
	f8_regfile u_regfile (
		.clk(clk),
		.wr(wr),
		.x(x),
		.y(y),
		.z(),
		.next_x(),
		.next_y(),
		.next_z()
	);

	f8_execute u_execute (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.x(x),
		.y(y),
		.dread_data(dread_data),
		.wr(wr),
		.dwrite(dwrite),
		.next_flags(next_flags),
		.trap(trap)
	);

endmodule

`default_nettype wire

/* hdl/f8_execute.sv */
// f8 execute stage
`default_nettype none

module f8_execute (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [23:0]            inst,
	input  logic [15:0]            x,
	input  logic [15:0]            y,
	input  logic [15:0]            dread_data,
	output f8_bus_pkg::reg_write_t wr,
	output f8_bus_pkg::dwrite_t    dwrite,
	output f8_isa_pkg::flags_t     next_flags,
	output logic                   trap
);
	import f8_isa_pkg::*;
	import f8_bus_pkg::*;

	opcode_t     opcode;
	logic [7:0]  xl;
	logic [7:0]  imm8;
	logic [15:0] imm16;
	flags_t      flags;
	alu_req_t    alu_req;
	alu_rsp_t    alu_rsp;
	logic        upd_zn;
	logic        upd_co;

	assign opcode = opcode_t'(inst[7:0]);
	assign xl = x[7:0];
	assign imm8 = inst[15:8];
	assign imm16 = inst[23:8];

	f8_alu u_alu (
		.req(alu_req),
		.rsp(alu_rsp)
	);

	// operation, operands and which flags it touches
	always_comb
	begin
		alu_req.op = PASSW;
		alu_req.a = {8'h00, xl};
		alu_req.b = 16'h0000;
		upd_zn = 1'b0;
		upd_co = 1'b0;
		case (opcode)
			LD_XL_IMMD:
			begin
				alu_req.op = PASS;
				alu_req.b = {8'h00, imm8};
				upd_zn = 1'b1;
			end
			ADD_XL_IMMD, SUB_XL_IMMD:
			begin
				alu_req.op = (opcode == ADD_XL_IMMD) ? ADD : SUB;
				alu_req.b = {8'h00, imm8};
				upd_zn = 1'b1;
				upd_co = 1'b1;
			end
			AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD:
			begin
				alu_req.op = (opcode == AND_XL_IMMD) ? AND : (opcode == OR_XL_IMMD) ? OR : XOR;
				alu_req.b = {8'h00, imm8};
				upd_zn = 1'b1;
			end
			INC_XL, DEC_XL:
			begin
				alu_req.op = (opcode == INC_XL) ? INC : DEC;
				upd_zn = 1'b1;
				upd_co = 1'b1;
			end
			LDW_Y_IMMD:
			begin
				alu_req.b = imm16;
				upd_zn = 1'b1;
			end
			ADDW_Y_D:
			begin
				alu_req.op = ADDSW;
				alu_req.a = y;
				alu_req.b = {8'h00, imm8};
				upd_zn = 1'b1;
				upd_co = 1'b1;
			end
			LDW_X_Y, LDW_Z_Y, LDW_DIR_Y:
				alu_req.b = y;
			LD_XL_DIR:
			begin
				alu_req.op = PASS;
				alu_req.b = dread_data;
				upd_zn = 1'b1;
			end
			LD_DIR_XL:
			begin
				alu_req.op = PASS;
				alu_req.b = {8'h00, xl};
			end
			default:
				;
		endcase
	end

	// register and memory writes
	always_comb
	begin
		wr.sel = REG_SEL_X;
		wr.en = 2'b00;
		wr.data = alu_rsp.result;
		dwrite.addr = imm16;
		dwrite.data = alu_rsp.result;
		dwrite.en = 2'b00;
		case (opcode)
			LD_XL_IMMD, ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD,
			INC_XL, DEC_XL, LD_XL_DIR:
				wr.en = 2'b01;
			LDW_Y_IMMD, ADDW_Y_D:
			begin
				wr.sel = REG_SEL_Y;
				wr.en = 2'b11;
			end
			LDW_X_Y:
				wr.en = 2'b11;
			LDW_Z_Y:
			begin
				wr.sel = REG_SEL_Z;
				wr.en = 2'b11;
			end
			LD_DIR_XL:
				dwrite.en = 2'b01;
			LDW_DIR_Y:
				dwrite.en = 2'b11;
			default:
				;
		endcase
	end

	always_comb
	begin
		next_flags = flags;
		if (upd_zn)
		begin
			next_flags.z = alu_rsp.flags.z;
			next_flags.n = alu_rsp.flags.n;
		end
		if (upd_co)
		begin
			next_flags.c = alu_rsp.flags.c;
			next_flags.o = alu_rsp.flags.o;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	assign trap = (opcode == TRAP);

	// a lone high-byte store has no opcode
	a_no_high_only: assert property (@(posedge clk) disable iff (reset) dwrite.en != 2'b10);

endmodule

`default_nettype wire

/* hdl/f8_fetch.sv */
// f8 instruction fetch
`default_nettype none
`include "f8_settings.svh"

module f8_fetch (
	input  logic               clk,
	input  logic               reset,
	input  logic [23:0]        iread_data,
	input  f8_isa_pkg::flags_t next_flags,
	output logic [15:0]        iread_addr,
	output logic [15:0]        dread_addr,
	output logic [23:0]        inst
);
	import f8_isa_pkg::*;

	logic [15:0] pc;
	logic [15:0] next_pc;
	logic [15:0] rel_target;
	opcode_t     next_op;
	logic        taken;

	// word arriving from instruction memory sits at pc
	assign next_op = opcode_t'(iread_data[7:0]);
	assign rel_target = pc + {{8{iread_data[15]}}, iread_data[15:8]};

	// branch condition on the flags after the executing instruction
	always_comb
	begin
		case (next_op)
			JR_D:
				taken = 1'b1;
			JRZ_D:
				taken = next_flags.z;
			JRNZ_D:
				taken = !next_flags.z;
			JRC_D:
				taken = next_flags.c;
			default:
				taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset)
			next_pc = `F8_RESET_VECTOR;
		else if (next_op == JP_IMMD)
			next_pc = iread_data[23:8];
		else if (taken)
			next_pc = rel_target;
		else
			next_pc = pc + 16'(inst_size(next_op));
	end

	assign iread_addr = next_pc;

	// only direct loads read data memory
	assign dread_addr = (next_op == LD_XL_DIR) ? iread_data[23:8] : 16'h0000;

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
		if (reset)
			inst <= {16'h0000, NOP};
		else
			inst <= iread_data;
	end

	a_pc_after_reset: assert property (@(posedge clk) reset |=> pc == `F8_RESET_VECTOR);

endmodule

`default_nettype wire

/* hdl/f8_regfile.sv */
// f8 register file
`default_nettype none

module f8_regfile (
	input  logic                   clk,
	input  f8_bus_pkg::reg_write_t wr,
	output logic [15:0]            x,
	output logic [15:0]            y,
	output logic [15:0]            z,
	output logic [15:0]            next_x,
	output logic [15:0]            next_y,
	output logic [15:0]            next_z
);
	import f8_bus_pkg::*;

	// byte-wise merge of a write into one register
	function automatic logic [15:0] merge(input logic [15:0] cur, input logic hit,
		input reg_write_t w);
		logic [15:0] res;
		res = cur;
		if (hit && w.en[0])
			res[7:0] = w.data[7:0];
		if (hit && w.en[1])
			res[15:8] = w.data[15:8];
		return res;
	endfunction

	assign next_x = merge(x, wr.sel == REG_SEL_X, wr);
	assign next_y = merge(y, wr.sel == REG_SEL_Y, wr);
	assign next_z = merge(z, wr.sel == REG_SEL_Z, wr);

	always_ff @(posedge clk)
	begin
		x <= next_x;
		y <= next_y;
		z <= next_z;
	end

	// execute must never address the missing fourth register
	a_sel_valid: assert property (@(posedge clk) wr.en != 2'b00 |-> wr.sel != 2'd3);

endmodule

`default_nettype wire

/* hdl/f8_alu.sv */
// f8 ALU
`default_nettype none

module f8_alu (
	input  f8_bus_pkg::alu_req_t req,
	output f8_bus_pkg::alu_rsp_t rsp
);
	import f8_isa_pkg::*;

	logic [7:0]  a8;
	logic [7:0]  b8;
	logic [15:0] b_sext;
	logic [8:0]  r8;
	logic [16:0] r16;
	logic        wide;
	logic        ovf;

	assign a8 = req.a[7:0];
	assign b8 = req.b[7:0];
	assign b_sext = {{8{b8[7]}}, b8};

	// bit 8 of r8 holds carry or borrow
	always_comb
	begin
		r8 = 9'h000;
		r16 = 17'h00000;
		wide = 1'b0;
		ovf = 1'b0;
		case (req.op)
			ADD:
			begin
				r8 = {1'b0, a8} + {1'b0, b8};
				ovf = (a8[7] == b8[7]) && (r8[7] != a8[7]);
			end
			SUB:
			begin
				r8 = {1'b0, a8} - {1'b0, b8};
				ovf = (a8[7] != b8[7]) && (r8[7] != a8[7]);
			end
			AND:
				r8 = {1'b0, a8 & b8};
			OR:
				r8 = {1'b0, a8 | b8};
			XOR:
				r8 = {1'b0, a8 ^ b8};
			INC:
			begin
				r8 = {1'b0, a8} + 9'd1;
				ovf = (r8[7:0] == 8'h80);
			end
			DEC:
			begin
				r8 = {1'b0, a8} - 9'd1;
				ovf = (r8[7:0] == 8'h7f);
			end
			PASSW:
			begin
				r16 = {1'b0, req.b};
				wide = 1'b1;
			end
			ADDSW:
			begin
				r16 = {1'b0, req.a} + {1'b0, b_sext};
				ovf = (req.a[15] == b_sext[15]) && (r16[15] != req.a[15]);
				wide = 1'b1;
			end
			default:
				r8 = {1'b0, b8};
		endcase
	end

	assign rsp.result = wide ? r16[15:0] : {8'h00, r8[7:0]};
	assign rsp.flags.c = wide ? r16[16] : r8[8];
	assign rsp.flags.z = wide ? (r16[15:0] == 16'h0000) : (r8[7:0] == 8'h00);
	assign rsp.flags.n = wide ? r16[15] : r8[7];
	assign rsp.flags.o = ovf;

endmodule

`default_nettype wire

/* hdl/f8_bus_pkg.sv */
// f8 internal and memory buses
`default_nettype none
`include "f8_settings.svh"

package f8_bus_pkg;

	// register select encoding
	localparam logic [1:0] REG_SEL_X = 2'd0;
	localparam logic [1:0] REG_SEL_Y = 2'd1;
	localparam logic [1:0] REG_SEL_Z = 2'd2;

	typedef struct packed {
		logic [`F8_WORD_W-1:0] addr;
		logic [`F8_WORD_W-1:0] data;
		logic [1:0]            en;
	} dwrite_t;

	typedef struct packed {
		logic [1:0]            sel;
		logic [1:0]            en;
		logic [`F8_WORD_W-1:0] data;
	} reg_write_t;

	typedef struct packed {
		f8_isa_pkg::alu_op_t   op;
		logic [`F8_WORD_W-1:0] a;
		logic [`F8_WORD_W-1:0] b;
	} alu_req_t;

	typedef struct packed {
		logic [`F8_WORD_W-1:0] result;
		f8_isa_pkg::flags_t    flags;
	} alu_rsp_t;

endpackage

`default_nettype wire

/* hdl/f8_isa_pkg.sv */
// f8 instruction set
`default_nettype none
`include "f8_settings.svh"

package f8_isa_pkg;

	typedef enum logic [`F8_BYTE_W-1:0] {
		NOP         = 8'h00,
		LD_XL_IMMD  = 8'h01,
		ADD_XL_IMMD = 8'h02,
		SUB_XL_IMMD = 8'h03,
		AND_XL_IMMD = 8'h04,
		OR_XL_IMMD  = 8'h05,
		XOR_XL_IMMD = 8'h06,
		INC_XL      = 8'h07,
		DEC_XL      = 8'h08,
		LDW_Y_IMMD  = 8'h10,
		ADDW_Y_D    = 8'h11,
		LDW_X_Y     = 8'h12,
		LDW_Z_Y     = 8'h13,
		LD_DIR_XL   = 8'h20,
		LD_XL_DIR   = 8'h21,
		LDW_DIR_Y   = 8'h22,
		JP_IMMD     = 8'h30,
		JR_D        = 8'h31,
		JRZ_D       = 8'h32,
		JRNZ_D      = 8'h33,
		JRC_D       = 8'h34,
		TRAP        = 8'hff
	} opcode_t;

	typedef enum logic [3:0] {
		PASS,
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		INC,
		DEC,
		PASSW,
		ADDSW
	} alu_op_t;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
		logic o;
	} flags_t;

	// length in bytes with unknown opcodes counted as 1-byte nops
	function automatic logic [1:0] inst_size(input opcode_t op);
		case (op)
			LD_XL_IMMD, ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD,
			ADDW_Y_D, JR_D, JRZ_D, JRNZ_D, JRC_D:
				return 2'd2;
			LDW_Y_IMMD, LD_DIR_XL, LD_XL_DIR, LDW_DIR_Y, JP_IMMD:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage

`default_nettype wire

/* hdl/f8_settings.svh */
// f8 core settings
`ifndef F8_SETTINGS_SVH
`define F8_SETTINGS_SVH

// first instruction fetched after reset
`define F8_RESET_VECTOR 16'h4000

// datapath widths
`define F8_WORD_W 16
`define F8_BYTE_W 8

`endif
